// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // word width shared by the dbus and the cbus
    localparam int DATA_WIDTH = 32;
    localparam int DATA_BYTES = 4;
    localparam int ADDR_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [DATA_BYTES-1:0] byte_en_t;
    typedef logic [ADDR_WIDTH-1:0] bus_addr_t;

    // cpu side request, held until addr_ok
    typedef struct packed {
        logic      valid;
        logic      is_write;
        bus_addr_t addr;
        byte_en_t  write_en;
        word_t     data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    // burst length as a power of two
    typedef enum logic [1:0] {
        LEN_1,
        LEN_2,
        LEN_4,
        LEN_8
    } cbus_order_t;

    // memory side request, stable for the whole burst
    typedef struct packed {
        logic        valid;
        logic        is_write;
        bus_addr_t   addr;
        cbus_order_t order;
        word_t       wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // 4 ways, 4 sets, 4 words per line
    localparam int WAY_BITS    = 2;
    localparam int INDEX_BITS  = 2;
    localparam int OFFSET_BITS = 2;
    localparam int ALIGN_BITS  = 2;
    localparam int TAG_BITS    = 26;

    localparam int NUM_WAYS  = 2 ** WAY_BITS;
    localparam int NUM_SETS  = 2 ** INDEX_BITS;
    localparam int NUM_WORDS = 2 ** OFFSET_BITS;
    localparam int PLRU_BITS = NUM_WAYS - 1;
    localparam int RAM_DEPTH = NUM_WAYS * NUM_SETS * NUM_WORDS;

    typedef logic [WAY_BITS-1:0]    way_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [PLRU_BITS-1:0]   plru_t;
    typedef logic [NUM_WORDS-1:0]   ready_bits_t;

    // byte address split into its cache fields
    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] zeros;
    } line_addr_t;

    // word address in the data ram
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } record_t;

    typedef struct packed {
        record_t [NUM_WAYS-1:0] records;
        tag_t [NUM_WAYS-1:0]    tags;
        plru_t                  plru;
    } set_info_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_READ,
        MISS_WRITE
    } miss_state_t;

endpackage

`default_nettype wire

// File: hw/set_store.sv
`timescale 1ns/1ps
`default_nettype none

module set_store
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  index_t    index,
    output set_info_t info,
    input  logic      hit,
    input  logic      hit_write,
    input  way_t      hit_way,
    input  plru_t     new_plru,
    input  logic      alloc,
    input  way_t      alloc_way,
    input  tag_t      alloc_tag
);

    // one record per set, kept in flops for a same cycle read
    set_info_t sets [NUM_SETS];

    assign info = sets[index];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                sets[s].records <= '0;
                sets[s].plru    <= '0;
            end
        end else if (hit) begin
            sets[index].plru <= new_plru;
            // a write hit leaves the line dirty
            if (hit_write) begin
                sets[index].records[hit_way].dirty <= 1'b1;
            end
        end else if (alloc) begin
            // refilled line starts clean under its new tag
            sets[index].records[alloc_way].valid <= 1'b1;
            sets[index].records[alloc_way].dirty <= 1'b0;
            sets[index].tags[alloc_way]          <= alloc_tag;
        end
    end

    // hit and allocate come from one request and never coincide
    hit_alloc_excl: assert property (
        @(posedge clk) disable iff (resetn)
        !(hit && alloc)
    );

endmodule

`default_nettype wire

// File: hw/plru_tree.sv
`timescale 1ns/1ps
`default_nettype none

module plru_tree
    import dcache_pkg::*;
(
    input  plru_t tree,
    input  way_t  used_way,
    output way_t  victim,
    output plru_t new_tree
);

    // tree[0] is the root, tree[1] covers ways 0/1, tree[2] covers ways 2/3
    // a bit at 0 points left, toward the lower way
    always_comb begin
        if (tree[0]) begin
            victim = {1'b1, tree[2]};
        end else begin
            victim = {1'b0, tree[1]};
        end
    end

    // point every node on the used path away from the used way
    always_comb begin
        new_tree    = tree;
        new_tree[0] = ~used_way[1];
        if (used_way[1]) begin
            new_tree[2] = ~used_way[0];
        end else begin
            new_tree[1] = ~used_way[0];
        end
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic      clk,
    input  ram_addr_t addr_1,
    input  ram_addr_t addr_2,
    input  byte_en_t  wen_1,
    input  byte_en_t  wen_2,
    input  word_t     wdata_1,
    input  word_t     wdata_2,
    output word_t     rdata_1,
    output word_t     rdata_2
);

    word_t mem [RAM_DEPTH];

    // read first on both ports, so each output holds the word before the write
    always_ff @(posedge clk) begin
        rdata_1 <= mem[addr_1];
        rdata_2 <= mem[addr_2];
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (wen_1[b]) begin
                mem[addr_1][8*b +: 8] <= wdata_1[8*b +: 8];
            end
            if (wen_2[b]) begin
                mem[addr_2][8*b +: 8] <= wdata_2[8*b +: 8];
            end
        end
    end

    // refill words are hit only after arrival, so the ports never collide
    no_write_clash: assert property (
        @(posedge clk)
        !((|wen_1) && (|wen_2) && (addr_1 == addr_2))
    );

endmodule

`default_nettype wire

// File: hw/miss_unit.sv
`timescale 1ns/1ps
`default_nettype none

module miss_unit
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        alloc,
    input  line_addr_t  alloc_addr,
    input  way_t        alloc_way,
    input  record_t     victim_record,
    input  tag_t        victim_tag,
    output logic        busy,
    output logic        avail,
    output line_addr_t  line,
    output way_t        way,
    output ready_bits_t ready_bits,
    output ram_addr_t   ram_addr,
    output byte_en_t    ram_wen,
    output word_t       ram_wdata,
    input  word_t       ram_rdata,
    output cbus_req_t   cbus_req,
    input  cbus_resp_t  cbus_resp
);

    miss_state_t state;
    offset_t     pos;
    record_t     vrecord;
    tag_t        vtag;
    word_t       vbuf [NUM_WORDS];

    // the victim buffer write trails the refill beat by one cycle
    logic        vwen;
    offset_t     voffset;
    logic        victim_dirty;

    assign victim_dirty = vrecord.valid && vrecord.dirty;

    assign busy  = state != MISS_IDLE;
    assign avail = (state == MISS_IDLE) || (state == MISS_WRITE && cbus_resp.last);

    // port 2 of the data ram follows the burst position
    assign ram_addr  = '{way: way, index: line.index, offset: pos};
    assign ram_wen   = (state == MISS_READ && cbus_resp.okay) ? '1 : '0;
    assign ram_wdata = cbus_resp.rdata;

    assign cbus_req.valid    = busy;
    assign cbus_req.is_write = state == MISS_WRITE;
    assign cbus_req.addr     = bus_addr_t'(line);
    assign cbus_req.order    = LEN_4;
    assign cbus_req.wdata    = vbuf[pos];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state      <= MISS_IDLE;
            ready_bits <= '0;
            vwen       <= 1'b0;
        end else begin
            vwen    <= (state == MISS_READ) && cbus_resp.okay;
            voffset <= pos;

            case (state)
                MISS_READ: begin
                    if (cbus_resp.okay) begin
                        ready_bits[pos] <= 1'b1;
                        pos             <= offset_t'(pos + 1'b1);
                    end
                    // writeback reuses the start offset, only the tag changes
                    if (cbus_resp.last) begin
                        state    <= victim_dirty ? MISS_WRITE : MISS_IDLE;
                        line.tag <= vtag;
                    end
                end
                MISS_WRITE: begin
                    if (cbus_resp.okay) begin
                        pos <= offset_t'(pos + 1'b1);
                    end
                    if (cbus_resp.last) begin
                        state <= MISS_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // a new miss overrides the end of a writeback
            if (alloc) begin
                state      <= MISS_READ;
                line       <= '{tag: alloc_addr.tag, index: alloc_addr.index,
                                offset: alloc_addr.offset, zeros: '0};
                way        <= alloc_way;
                pos        <= alloc_addr.offset;
                ready_bits <= '0;
                vrecord    <= victim_record;
                vtag       <= victim_tag;
            end
        end
    end

    // old line words, captured from the read-first port
    always_ff @(posedge clk) begin
        if (vwen) begin
            vbuf[voffset] <= ram_rdata;
        end
    end

    cbus_addr_stable: assert property (
        @(posedge clk) disable iff (resetn)
        (cbus_req.valid && !cbus_resp.last)
            |=> $stable(cbus_req.addr) && $stable(cbus_req.is_write)
    );

endmodule

`default_nettype wire

// File: hw/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  dbus_req_t  dbus_req,
    output dbus_resp_t dbus_resp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    line_addr_t          req_addr;
    set_info_t           info;
    logic [NUM_WAYS-1:0] hit_bits;
    logic                req_hit;
    way_t                hit_way;
    way_t                victim;
    plru_t               new_plru;

    logic                to_hit;
    logic                to_miss;
    logic                in_miss;
    logic                word_ready;
    logic                data_ok;

    logic                miss_busy;
    logic                miss_avail;
    line_addr_t          miss_line;
    way_t                miss_way;
    ready_bits_t         miss_ready;

    ram_addr_t           hit_pos;
    byte_en_t            hit_wen;
    word_t               hit_rdata;
    ram_addr_t           miss_pos;
    byte_en_t            miss_wen;
    word_t               miss_wdata;
    word_t               miss_rdata;

    assign req_addr = line_addr_t'(dbus_req.addr);

    // tag match across the ways of the set
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_match
        assign hit_bits[w] = info.records[w].valid && (info.tags[w] == req_addr.tag);
    end

    assign req_hit = |hit_bits;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_bits[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // words of the refilling line wait for their ready bit
    assign in_miss = miss_busy && (hit_way == miss_way) &&
                     (req_addr.tag == miss_line.tag) && (req_addr.index == miss_line.index);
    assign word_ready = miss_ready[req_addr.offset];

    assign to_hit  = dbus_req.valid && req_hit && (!in_miss || word_ready);
    assign to_miss = dbus_req.valid && !req_hit && miss_avail;

    assign hit_pos = '{way: hit_way, index: req_addr.index, offset: req_addr.offset};
    assign hit_wen = (to_hit && dbus_req.is_write) ? dbus_req.write_en : '0;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= to_hit;
        end
    end

    assign dbus_resp.addr_ok = to_hit;
    assign dbus_resp.data_ok = data_ok;
    assign dbus_resp.data    = hit_rdata;

    set_store u_set_store (
        .clk      (clk),
        .resetn   (resetn),
        .index    (req_addr.index),
        .info     (info),
        .hit      (to_hit),
        .hit_write(dbus_req.is_write),
        .hit_way  (hit_way),
        .new_plru (new_plru),
        .alloc    (to_miss),
        .alloc_way(victim),
        .alloc_tag(req_addr.tag)
    );

    plru_tree u_plru_tree (
        .tree    (info.plru),
        .used_way(hit_way),
        .victim  (victim),
        .new_tree(new_plru)
    );

    data_ram u_data_ram (
        .clk    (clk),
        .addr_1 (hit_pos),
        .addr_2 (miss_pos),
        .wen_1  (hit_wen),
        .wen_2  (miss_wen),
        .wdata_1(dbus_req.data),
        .wdata_2(miss_wdata),
        .rdata_1(hit_rdata),
        .rdata_2(miss_rdata)
    );

    miss_unit u_miss_unit (
        .clk          (clk),
        .resetn       (resetn),
        .alloc        (to_miss),
        .alloc_addr   (req_addr),
        .alloc_way    (victim),
        .victim_record(info.records[victim]),
        .victim_tag   (info.tags[victim]),
        .busy         (miss_busy),
        .avail        (miss_avail),
        .line         (miss_line),
        .way          (miss_way),
        .ready_bits   (miss_ready),
        .ram_addr     (miss_pos),
        .ram_wen      (miss_wen),
        .ram_wdata    (miss_wdata),
        .ram_rdata    (miss_rdata),
        .cbus_req     (cbus_req),
        .cbus_resp    (cbus_resp)
    );

    // a line lives in at most one way of its set
    hit_onehot: assert property (
        @(posedge clk) disable iff (resetn)
        $onehot0(hit_bits)
    );

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import bus_pkg::*;
    import dcache_pkg::*;
();

    localparam int NUM_RANDOM   = 300;
    // about 100 directed accesses on top, 50 cycles covers two stalled bursts
    localparam int CYCLE_LIMIT  = (NUM_RANDOM + 100) * 50;
    localparam int ACCEPT_LIMIT = 100;
    localparam int MEM_WORDS    = 256;

    logic       clk;
    logic       resetn = 1'b1;
    dbus_req_t  dbus_req = '0;
    dbus_resp_t dbus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp = '0;

    int seed = 32'h5bbc57f6;

    // memory behind the cbus and the reference image seen by the cpu
    word_t mem [MEM_WORDS];
    word_t golden [MEM_WORDS];
    logic  stall_pattern [MEM_WORDS];
    logic [7:0] stall_idx = '0;
    logic [1:0] beat;
    logic [7:0] beat_word;

    bus_addr_t rand_addr [NUM_RANDOM];
    logic      rand_write [NUM_RANDOM];
    byte_en_t  rand_wen [NUM_RANDOM];
    word_t     rand_data [NUM_RANDOM];

    // values taken mid cycle, consumed at the next rising edge
    dbus_req_t  snap_req;
    logic       snap_accept;
    logic       snap_okay;
    logic       snap_last;
    logic       snap_write;
    word_t      snap_wdata;
    logic [7:0] snap_word;

    logic       prev_accept;
    bus_addr_t  exp_addr;
    word_t      exp_data;
    logic       after_reset;
    logic [7:0] wait_count;

    int data_errors = 0;
    int handshake_errors = 0;
    int cbus_errors = 0;
    int reset_errors = 0;
    int hang_errors = 0;

    dcache uut (
        .clk      (clk),
        .resetn   (resetn),
        .dbus_req (dbus_req),
        .dbus_resp(dbus_resp),
        .cbus_req (cbus_req),
        .cbus_resp(cbus_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t fill_word(int n);
        return 32'h5a00_0000 + word_t'(n) * 32'h0001_0101;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, byte_en_t wen);
        word_t merged;
        merged = old;
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (wen[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // bursts wrap inside the line, starting at the requested word
    function automatic logic [7:0] burst_word(bus_addr_t addr, logic [1:0] beat_num);
        logic [1:0] offset;
        offset = addr[3:2] + beat_num;
        return {addr[9:4], offset};
    endfunction

    assign beat_word = burst_word(cbus_req.addr, beat);

    always @(negedge clk) begin
        snap_req    = dbus_req;
        snap_accept = dbus_req.valid && dbus_resp.addr_ok;
        snap_okay   = cbus_resp.okay;
        snap_last   = cbus_resp.last;
        snap_write  = cbus_req.is_write;
        snap_wdata  = cbus_req.wdata;
        snap_word   = beat_word;
    end

    always @(posedge clk) begin
        after_reset <= resetn;
        stall_idx   <= stall_idx + 8'd1;
        if (resetn) begin
            prev_accept <= 1'b0;
            wait_count  <= '0;
            beat        <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i]    <= fill_word(i);
                golden[i] <= fill_word(i);
            end
        end else begin
            prev_accept <= snap_accept;
            exp_addr    <= snap_req.addr;
            // old word is expected, the write lands afterwards
            exp_data    <= golden[snap_req.addr[9:2]];
            if (snap_accept && snap_req.is_write) begin
                golden[snap_req.addr[9:2]] <= merge_bytes(golden[snap_req.addr[9:2]],
                                                          snap_req.data, snap_req.write_en);
            end
            wait_count <= (snap_req.valid && !snap_accept) ? wait_count + 8'd1 : '0;
            if (snap_okay) begin
                if (snap_write) begin
                    mem[snap_word] <= snap_wdata;
                end
                beat <= snap_last ? 2'd0 : beat + 2'd1;
            end
        end
    end

    // cbus memory model with random idle cycles between beats
    always @(posedge clk) begin
        #1;
        if (!resetn && cbus_req.valid && !stall_pattern[stall_idx]) begin
            cbus_resp.okay  = 1'b1;
            cbus_resp.last  = beat == 2'd3;
            cbus_resp.rdata = cbus_req.is_write ? '0 : mem[beat_word];
        end else begin
            cbus_resp = '0;
        end
    end

    data_match: assert property (
        @(negedge clk) disable iff (resetn)
        prev_accept |-> dbus_resp.data == exp_data
    ) else begin
        data_errors++;
        $display("CHECK FAILED dbus_resp.data at %h: got %h, expected %h",
                 exp_addr, dbus_resp.data, exp_data);
    end

    data_ok_timing: assert property (
        @(negedge clk) disable iff (resetn)
        dbus_resp.data_ok == prev_accept
    ) else begin
        handshake_errors++;
        $display("CHECK FAILED dbus_resp.data_ok: got %h, expected %h",
                 dbus_resp.data_ok, prev_accept);
    end

    burst_hold: assert property (
        @(negedge clk) disable iff (resetn)
        (cbus_req.valid && !(cbus_resp.okay && cbus_resp.last))
            |=> cbus_req.valid && $stable(cbus_req.addr) && $stable(cbus_req.is_write)
    ) else begin
        cbus_errors++;
        $display("cbus request dropped or changed before the last beat of its burst");
    end

    burst_order: assert property (
        @(negedge clk) disable iff (resetn)
        cbus_req.valid |-> cbus_req.order == LEN_4
    ) else begin
        cbus_errors++;
        $display("CHECK FAILED cbus_req.order: got %h, expected %h", cbus_req.order, LEN_4);
    end

    burst_complete: assert property (
        @(negedge clk) disable iff (resetn)
        !cbus_req.valid |-> beat == 2'd0
    ) else begin
        cbus_errors++;
        $display("cbus burst ended before its fourth beat");
    end

    writeback_data: assert property (
        @(negedge clk) disable iff (resetn)
        (cbus_req.valid && cbus_req.is_write && cbus_resp.okay)
            |-> cbus_req.wdata == golden[beat_word]
    ) else begin
        cbus_errors++;
        $display("CHECK FAILED cbus_req.wdata at word %h: got %h, expected %h",
                 beat_word, cbus_req.wdata, golden[beat_word]);
    end

    reset_quiet: assert property (
        @(negedge clk)
        (resetn || after_reset) |-> !dbus_resp.data_ok && !cbus_req.valid
    ) else begin
        reset_errors++;
        $display("CHECK FAILED dbus_resp.data_ok/cbus_req.valid near reset: got %h/%h",
                 dbus_resp.data_ok, cbus_req.valid);
    end

    accept_progress: assert property (
        @(negedge clk) disable iff (resetn)
        wait_count != 8'd65
    ) else begin
        hang_errors++;
        $display("request at address %h was not accepted within 64 cycles", dbus_req.addr);
    end

    // called and left 1 ns after a rising edge
    task automatic cpu_access(input bus_addr_t addr, input logic wr,
                              input byte_en_t wen, input word_t data);
        int waited;
        waited = 0;
        dbus_req = '{valid: 1'b1, is_write: wr, addr: addr, write_en: wen, data: data};
        @(negedge clk);
        while (!dbus_resp.addr_ok && waited < ACCEPT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        dbus_req.valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rnd;
        bus_addr_t   addr;
        int          total;

        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd = $random(seed);
            stall_pattern[i] = rnd[1:0] == 2'b00;
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            rand_addr[i]  = {24'd0, rnd[5:0], 2'b00};
            rand_write[i] = rnd[8];
            rand_wen[i]   = (rnd[15:12] == 4'd0) ? 4'hf : rnd[15:12];
            rand_data[i]  = $random(seed);
        end

        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b0;
        idle(2);

        // set 1 refill, later words hit while the burst runs
        cpu_access(32'h10, 1'b0, 4'h0, '0);
        cpu_access(32'h14, 1'b0, 4'h0, '0);
        cpu_access(32'h1c, 1'b0, 4'h0, '0);
        cpu_access(32'h18, 1'b0, 4'h0, '0);
        cpu_access(32'h14, 1'b1, 4'b0011, 32'hdead_beef);
        cpu_access(32'h14, 1'b0, 4'h0, '0);
        // write miss, then byte writes into the refilling line
        cpu_access(32'h24, 1'b1, 4'hf, 32'h0bad_f00d);
        cpu_access(32'h2c, 1'b1, 4'b1000, 32'h7700_0000);
        cpu_access(32'h20, 1'b0, 4'h0, '0);
        cpu_access(32'h2c, 1'b0, 4'h0, '0);
        idle(3);
        cpu_access(32'h30, 1'b1, 4'b0001, 32'h0000_00a1);
        cpu_access(32'h30, 1'b1, 4'b0100, 32'h00b2_0000);
        cpu_access(32'h30, 1'b0, 4'h0, '0);

        // five lines share set 0, so dirty lines get evicted
        for (int rep = 0; rep < 3; rep++) begin
            for (int i = 0; i < 5; i++) begin
                addr = bus_addr_t'(i * 64 + rep * 4);
                cpu_access(addr, 1'b1, byte_en_t'(4'b0101 << rep), {8'(i), 8'(rep), 16'h3c3c});
                cpu_access(addr + 32'd8, 1'b0, 4'h0, '0);
            end
        end
        for (int i = 0; i < 5; i++) begin
            for (int w = 0; w < 4; w++) begin
                cpu_access(bus_addr_t'(i * 64 + w * 4), 1'b0, 4'h0, '0);
            end
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            cpu_access(rand_addr[i], rand_write[i], rand_wen[i], rand_data[i]);
        end

        idle(2);
        while (cbus_req.valid) begin
            idle(1);
        end
        idle(2);

        total = data_errors + handshake_errors + cbus_errors + reset_errors + hang_errors;
        $display("errors: data %0d, handshake %0d, cbus %0d, reset %0d, hang %0d",
                 data_errors, handshake_errors, cbus_errors, reset_errors, hang_errors);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hw/bus_pkg.sv
hw/dcache_pkg.sv
hw/set_store.sv
hw/plru_tree.sv
hw/data_ram.sv
hw/miss_unit.sv
hw/dcache.sv
verif/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_dcache \
    -o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "testbench reported a failure"
    exit 1
fi

echo "testbench finished without failures"
